//--- hw/lc4_isa_pkg.sv
// LC4 instruction set definitions shared by the decoder, execute and memory stages
// the instruction word union gives one view per encoding format
package lc4_isa_pkg;

   localparam int NUM_REGS = 8;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;

   // major opcode in insn[15:12], only the kept subset is named
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ADD   = 4'b0001,
      OP_AND   = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   // condition flags, also the branch mask order
   typedef struct packed {
      logic n;
      logic z;
      logic p;
   } nzp_t;

   // ADD/AND register form, subop 000 is the plain op
   typedef struct packed {
      opcode_e  opcode;
      reg_sel_t rd;
      reg_sel_t rs;
      logic [2:0] subop;
      reg_sel_t rt;
   } rr_fmt_t;

   // ADD/AND immediate form, form bit overlays subop[2]
   typedef struct packed {
      opcode_e  opcode;
      reg_sel_t rd;
      reg_sel_t rs;
      logic     imm_form;
      logic [4:0] imm5;
   } ri_fmt_t;

   // LDR/STR, rd holds rt for a store
   typedef struct packed {
      opcode_e  opcode;
      reg_sel_t rd;
      reg_sel_t rs;
      logic [5:0] imm6;
   } mem_fmt_t;

   typedef struct packed {
      opcode_e  opcode;
      nzp_t     nzp;
      logic [8:0] imm9;
   } br_fmt_t;

   typedef struct packed {
      opcode_e  opcode;
      reg_sel_t rd;
      logic [8:0] imm9;
   } const_fmt_t;

   typedef union packed {
      rr_fmt_t    rr;
      ri_fmt_t    ri;
      mem_fmt_t   mem;
      br_fmt_t    br;
      const_fmt_t cnst;
   } insn_u;

   // flags of a result taken as a signed value
   function automatic nzp_t nzp_of(word_t value);
      nzp_t flags;
      flags.n = value[15];
      flags.z = (value == '0);
      flags.p = !value[15] && (value != '0);
      return flags;
   endfunction

endpackage

//--- hw/lc4_pipe_pkg.sv
// pipeline register and control layouts passed between the LC4 stages
// bubbles are entries whose ctrl is all zero
package lc4_pipe_pkg;
   import lc4_isa_pkg::*;

   // what execute computes for the kept operations
   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_AND,
      ALU_CONST,
      ALU_BRANCH
   } alu_op_e;

   typedef struct packed {
      logic    valid;
      logic    rs_re;
      logic    rt_re;
      logic    rf_we;
      logic    nzp_we;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      // operand b from the instruction instead of rt
      logic    use_imm;
      alu_op_e alu_op;
   } ctrl_t;

   // F/D register
   typedef struct packed {
      word_t pc;
      insn_u insn;
      logic  valid;
   } fd_t;

   // D/X register
   typedef struct packed {
      word_t    pc;
      insn_u    insn;
      ctrl_t    ctrl;
      reg_sel_t rs_sel;
      reg_sel_t rt_sel;
      reg_sel_t wsel;
      word_t    rs_data;
      word_t    rt_data;
   } dx_t;

   // X/M register
   typedef struct packed {
      word_t    pc;
      word_t    insn;
      ctrl_t    ctrl;
      reg_sel_t wsel;
      reg_sel_t rt_sel;
      word_t    result;
      word_t    store_data;
   } xm_t;

   // register write, also the source of WX and WM bypass
   typedef struct packed {
      logic     rf_we;
      reg_sel_t wsel;
      word_t    data;
   } wb_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_sel_t wsel;
      word_t    wdata;
   } retire_t;

endpackage

//--- hw/lc4_decoder.sv
// combinational decode of one LC4 instruction into register selects and control
// opcodes outside the kept subset come out as a no-op with valid low
`timescale 1ns/100ps
module lc4_decoder
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  insn_u    i_insn,
   output ctrl_t    o_ctrl,
   output reg_sel_t o_rs_sel,
   output reg_sel_t o_rt_sel,
   output reg_sel_t o_wsel
);

   always_comb begin
      o_ctrl   = '0;
      // field positions of rd/rs/rt line up across formats
      o_rs_sel = i_insn.rr.rs;
      o_rt_sel = i_insn.rr.rt;
      o_wsel   = i_insn.rr.rd;
      case (i_insn.rr.opcode)
         OP_ADD, OP_AND: begin
            // register form only for subop 000 since the others are dropped ops
            if (i_insn.ri.imm_form || i_insn.rr.subop == 3'b000) begin
               o_ctrl.valid   = 1'b1;
               o_ctrl.rs_re   = 1'b1;
               o_ctrl.rt_re   = !i_insn.ri.imm_form;
               o_ctrl.rf_we   = 1'b1;
               o_ctrl.nzp_we  = 1'b1;
               o_ctrl.use_imm = i_insn.ri.imm_form;
               o_ctrl.alu_op  = (i_insn.rr.opcode == OP_AND) ? ALU_AND : ALU_ADD;
            end
         end
         OP_CONST: begin
            o_ctrl.valid  = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_CONST;
         end
         OP_LDR: begin
            o_ctrl.valid   = 1'b1;
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.is_load = 1'b1;
            o_ctrl.use_imm = 1'b1;
         end
         OP_STR: begin
            o_ctrl.valid    = 1'b1;
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.use_imm  = 1'b1;
            // store data register sits in the rd slot
            o_rt_sel        = i_insn.mem.rd;
         end
         OP_BR: begin
            // mask 000 is the NOP that retires but never redirects
            o_ctrl.valid     = 1'b1;
            o_ctrl.is_branch = 1'b1;
            o_ctrl.alu_op    = ALU_BRANCH;
         end
         default: ;
      endcase
   end

endmodule

//--- hw/lc4_regfile.sv
// eight-entry LC4 register file, two read ports and one write port
// a write is visible to a read in the same cycle
`timescale 1ns/100ps
module lc4_regfile
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic     gwe,
   input  logic     i_reset,
   input  reg_sel_t i_rs_sel,
   input  reg_sel_t i_rt_sel,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  wb_t      i_wb
);

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.rf_we) begin
         regs[i_wb.wsel] <= i_wb.data;
      end
   end

   // write-through so decode never sees the stale copy
   assign o_rs_data = (i_wb.rf_we && i_wb.wsel == i_rs_sel) ? i_wb.data : regs[i_rs_sel];
   assign o_rt_data = (i_wb.rf_we && i_wb.wsel == i_rt_sel) ? i_wb.data : regs[i_rt_sel];

endmodule

//--- hw/lc4_fetch.sv
// fetch stage of the LC4 pipeline, owns the PC and the F/D register
// redirect wins over stall, the slot being fetched is dropped
`timescale 1ns/100ps
module lc4_fetch
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
#(
   parameter word_t RESET_PC
) (
   input  logic  gwe,
   input  logic  i_reset,
   input  logic  i_stall,
   input  logic  i_redirect,
   input  word_t i_target,
   output word_t o_imem_addr,
   input  word_t i_imem_data,
   output fd_t   o_fd
);

   word_t pc_q;

   // instruction memory answers in the same cycle
   assign o_imem_addr = pc_q;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q       <= RESET_PC;
         o_fd.valid <= 1'b0;
      end else if (i_redirect) begin
         // fall-through fetch becomes a bubble
         pc_q       <= i_target;
         o_fd.valid <= 1'b0;
      end else if (!i_stall) begin
         pc_q       <= pc_q + 16'd1;
         o_fd.pc    <= pc_q;
         o_fd.insn  <= i_imem_data;
         o_fd.valid <= 1'b1;
      end
      // on stall PC and F/D just hold
   end

endmodule

//--- hw/lc4_decode_stage.sv
// decode stage with the decoder, register file read, load-use stall and the D/X register
// a stall or a redirect loads a bubble into D/X
`timescale 1ns/100ps
module lc4_decode_stage
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic gwe,
   input  logic i_reset,
   input  fd_t  i_fd,
   input  logic i_redirect,
   input  wb_t  i_wb,
   output logic o_stall,
   output dx_t  o_dx
);

   ctrl_t    dec_ctrl;
   reg_sel_t rs_sel;
   reg_sel_t rt_sel;
   reg_sel_t wsel;
   word_t    rs_data;
   word_t    rt_data;
   logic     dec_valid;
   logic     rs_hazard;
   logic     rt_hazard;

   lc4_decoder lc4_decoder_i (
      .i_insn   (i_fd.insn),
      .o_ctrl   (dec_ctrl),
      .o_rs_sel (rs_sel),
      .o_rt_sel (rt_sel),
      .o_wsel   (wsel)
   );

   lc4_regfile lc4_regfile_i (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wb      (i_wb)
   );

   assign dec_valid = i_fd.valid && dec_ctrl.valid;

   // D/X holds the instruction now in execute
   assign rs_hazard = dec_ctrl.rs_re && rs_sel == o_dx.wsel;
   // store data is patched in memory so rt of a store never stalls
   assign rt_hazard = dec_ctrl.rt_re && !dec_ctrl.is_store && rt_sel == o_dx.wsel;
   assign o_stall   = dec_valid && o_dx.ctrl.valid && o_dx.ctrl.is_load &&
                      (rs_hazard || rt_hazard);

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_dx.ctrl <= '0;
      end else begin
         o_dx.pc      <= i_fd.pc;
         o_dx.insn    <= i_fd.insn;
         o_dx.rs_sel  <= rs_sel;
         o_dx.rt_sel  <= rt_sel;
         o_dx.wsel    <= wsel;
         o_dx.rs_data <= rs_data;
         o_dx.rt_data <= rt_data;
         // a bubble clears every control bit and not only valid
         if (o_stall || i_redirect || !dec_valid) begin
            o_dx.ctrl <= '0;
         end else begin
            o_dx.ctrl <= dec_ctrl;
         end
      end
   end

   // the stalled instruction waits in F/D for one more decode
   a_stall_hold : assert property (@(posedge gwe) disable iff (i_reset)
      o_stall |=> $stable(i_fd));

endmodule

//--- hw/lc4_execute.sv
// execute stage with MX/WX operand bypass, the ALU for the kept ops, branch resolution
// and the X/M register while redirect comes combinationally from the D/X entry
`timescale 1ns/100ps
module lc4_execute
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic  gwe,
   input  logic  i_reset,
   input  dx_t   i_dx,
   input  wb_t   i_wb,
   input  nzp_t  i_cond,
   output logic  o_redirect,
   output word_t o_target,
   output xm_t   o_xm
);

   word_t rs_val;
   word_t rt_val;
   word_t imm_val;
   word_t op_b;
   word_t alu_res;

   // newest producer wins and a load in M has no value yet
   function automatic word_t bypass(reg_sel_t sel, word_t rf_val, xm_t xm, wb_t wb);
      if (xm.ctrl.rf_we && !xm.ctrl.is_load && xm.wsel == sel) begin
         return xm.result;
      end
      if (wb.rf_we && wb.wsel == sel) begin
         return wb.data;
      end
      return rf_val;
   endfunction

   always_comb begin
      rs_val = bypass(i_dx.rs_sel, i_dx.rs_data, o_xm, i_wb);
      rt_val = bypass(i_dx.rt_sel, i_dx.rt_data, o_xm, i_wb);
   end

   // imm6 for address offsets and imm5 for arithmetic
   assign imm_val = (i_dx.ctrl.is_load || i_dx.ctrl.is_store) ?
                    {{10{i_dx.insn.mem.imm6[5]}}, i_dx.insn.mem.imm6} :
                    {{11{i_dx.insn.ri.imm5[4]}}, i_dx.insn.ri.imm5};
   assign op_b = i_dx.ctrl.use_imm ? imm_val : rt_val;

   always_comb begin
      case (i_dx.ctrl.alu_op)
         ALU_ADD:    alu_res = rs_val + op_b;
         ALU_AND:    alu_res = rs_val & op_b;
         ALU_CONST:  alu_res = {{7{i_dx.insn.cnst.imm9[8]}}, i_dx.insn.cnst.imm9};
         // target is pc + 1 + offset
         ALU_BRANCH: alu_res = i_dx.pc + 16'd1 + {{7{i_dx.insn.br.imm9[8]}}, i_dx.insn.br.imm9};
         default:    alu_res = '0;
      endcase
   end

   // taken when the mask shares a flag with the current condition
   assign o_redirect = i_dx.ctrl.valid && i_dx.ctrl.is_branch &&
                       ((i_dx.insn.br.nzp & i_cond) != '0);
   assign o_target   = alu_res;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_xm.ctrl <= '0;
      end else begin
         o_xm.ctrl       <= i_dx.ctrl;
         o_xm.pc         <= i_dx.pc;
         o_xm.insn       <= i_dx.insn;
         o_xm.wsel       <= i_dx.wsel;
         o_xm.rt_sel     <= i_dx.rt_sel;
         o_xm.result     <= alu_res;
         o_xm.store_data <= rt_val;
      end
   end

   // a taken branch is followed by two bubbles from decode and fetch
   a_redirect_flush : assert property (@(posedge gwe) disable iff (i_reset)
      o_redirect |=> !i_dx.ctrl.valid ##1 !i_dx.ctrl.valid);

endmodule

//--- hw/lc4_memory_stage.sv
// memory stage with data memory access, WM store bypass, NZP register and the M/W register
// M/W feeds the regfile write, the WX/WM bypasses and the retire port
`timescale 1ns/100ps
module lc4_memory_stage
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic    gwe,
   input  logic    i_reset,
   input  xm_t     i_xm,
   output word_t   o_dmem_addr,
   output logic    o_dmem_we,
   output word_t   o_dmem_wdata,
   input  word_t   i_dmem_data,
   output nzp_t    o_cond,
   output wb_t     o_wb,
   output retire_t o_retire
);

   nzp_t  nzp_q;
   nzp_t  m_nzp;
   word_t m_result;
   logic  wm_hit;

   assign o_dmem_addr = (i_xm.ctrl.is_load || i_xm.ctrl.is_store) ? i_xm.result : '0;
   assign o_dmem_we   = i_xm.ctrl.valid && i_xm.ctrl.is_store;

   // a load just ahead of the store into its rt has its value only in M/W
   assign wm_hit       = i_xm.ctrl.is_store && o_wb.rf_we && o_wb.wsel == i_xm.rt_sel;
   assign o_dmem_wdata = wm_hit ? o_wb.data : i_xm.store_data;

   // read data is combinational
   assign m_result = i_xm.ctrl.is_load ? i_dmem_data : i_xm.result;
   assign m_nzp    = nzp_of(m_result);

   // branch in X sees the flags of the instruction right ahead of it
   assign o_cond = i_xm.ctrl.nzp_we ? m_nzp : nzp_q;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= '0;
      end else if (i_xm.ctrl.valid && i_xm.ctrl.nzp_we) begin
         nzp_q <= m_nzp;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_retire.valid <= 1'b0;
         o_retire.rf_we <= 1'b0;
      end else begin
         o_retire.valid <= i_xm.ctrl.valid;
         o_retire.rf_we <= i_xm.ctrl.rf_we;
         o_retire.pc    <= i_xm.pc;
         o_retire.insn  <= i_xm.insn;
         o_retire.wsel  <= i_xm.wsel;
         o_retire.wdata <= m_result;
      end
   end

   // writeback is the retiring record itself
   assign o_wb.rf_we = o_retire.rf_we;
   assign o_wb.wsel  = o_retire.wsel;
   assign o_wb.data  = o_retire.wdata;

   // a store writes neither a register nor the flags
   a_store_no_write : assert property (@(posedge gwe) disable iff (i_reset)
      o_dmem_we |-> !i_xm.ctrl.rf_we && !i_xm.ctrl.nzp_we);

endmodule

//--- hw/lc4_pipeline.sv
// top level of the five-stage LC4 pipeline
// instruction and data memories are outside and read combinationally
`timescale 1ns/100ps
module lc4_pipeline
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
#(
   parameter word_t RESET_PC = 16'h8200
) (
   input  logic    gwe,
   input  logic    i_reset,
   output word_t   o_imem_addr,
   input  word_t   i_imem_data,
   output word_t   o_dmem_addr,
   output logic    o_dmem_we,
   output word_t   o_dmem_wdata,
   input  word_t   i_dmem_data,
   output retire_t o_retire
);

   fd_t   fd;
   dx_t   dx;
   xm_t   xm;
   wb_t   wb;
   nzp_t  cond;
   logic  stall;
   logic  redirect;
   word_t target;

   lc4_fetch #(
      .RESET_PC (RESET_PC)
   ) lc4_fetch_i (
      .gwe         (gwe),
      .i_reset     (i_reset),
      .i_stall     (stall),
      .i_redirect  (redirect),
      .i_target    (target),
      .o_imem_addr (o_imem_addr),
      .i_imem_data (i_imem_data),
      .o_fd        (fd)
   );

   lc4_decode_stage lc4_decode_stage_i (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_fd       (fd),
      .i_redirect (redirect),
      .i_wb       (wb),
      .o_stall    (stall),
      .o_dx       (dx)
   );

   lc4_execute lc4_execute_i (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_dx       (dx),
      .i_wb       (wb),
      .i_cond     (cond),
      .o_redirect (redirect),
      .o_target   (target),
      .o_xm       (xm)
   );

   lc4_memory_stage lc4_memory_stage_i (
      .gwe          (gwe),
      .i_reset      (i_reset),
      .i_xm         (xm),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .i_dmem_data  (i_dmem_data),
      .o_cond       (cond),
      .o_wb         (wb),
      .o_retire     (o_retire)
   );

endmodule

//--- verif/lc4_pipeline_tb.sv
// testbench for the LC4 pipeline with models of the instruction and data memories
// program, data and expected retire/store records come from the vectors file
`timescale 1ns/100ps
module lc4_pipeline_tb
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
();

   localparam word_t FIRST_PC = 16'h8200;
   localparam int HALF_PERIOD = 2;
   localparam VECTOR_FILE = "verif/lc4_program_vectors.txt";

   // one expected retire where gap counts the idle retire cycles just before it
   typedef struct packed {
      word_t      pc;
      logic       rf_we;
      reg_sel_t   wsel;
      word_t      wdata;
      logic [7:0] gap;
   } exp_retire_t;

   typedef struct packed {
      word_t addr;
      word_t data;
   } exp_store_t;

   logic    gwe;
   logic    i_reset;
   word_t   o_imem_addr;
   word_t   i_imem_data;
   word_t   o_dmem_addr;
   logic    o_dmem_we;
   word_t   o_dmem_wdata;
   word_t   i_dmem_data;
   retire_t o_retire;

   word_t       imem [65536];
   word_t       dmem [65536];
   exp_retire_t retire_q [$];
   exp_store_t  store_q [$];
   int          idle_cycles;
   int          retire_total;
   logic        loaded;

   lc4_pipeline #(
      .RESET_PC (FIRST_PC)
   ) lc4_pipeline_i (
      .gwe          (gwe),
      .i_reset      (i_reset),
      .o_imem_addr  (o_imem_addr),
      .i_imem_data  (i_imem_data),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .i_dmem_data  (i_dmem_data),
      .o_retire     (o_retire)
   );

   initial begin
      gwe = 1'b0;
      forever begin
         #HALF_PERIOD gwe = ~gwe;
      end
   end

   task automatic fail_run();
      $display("RESULT: FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic value_mismatch(input string name, input word_t got, input word_t want);
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
      fail_run();
   endtask

   task automatic plain_failure(input string what);
      $display("%s", what);
      fail_run();
   endtask

   // tag letter followed by hex fields with # starting a comment line
   task automatic load_vectors();
      int          fd;
      int          c;
      int          n;
      word_t       f0;
      word_t       f1;
      word_t       f2;
      word_t       f3;
      word_t       f4;
      exp_retire_t r;
      exp_store_t  s;
      fd = $fopen(VECTOR_FILE, "r");
      assert (fd != 0) else plain_failure("the vectors file could not be opened");
      c = $fgetc(fd);
      while (c != -1) begin
         case (c)
            "#": begin
               while (c != -1 && c != "\n") begin
                  c = $fgetc(fd);
               end
            end
            "I", "D", "S": begin
               n = $fscanf(fd, "%h %h", f0, f1);
               assert (n == 2) else plain_failure("a memory or store line is malformed");
               if (c == "I") begin
                  imem[f0] = f1;
               end else if (c == "D") begin
                  dmem[f0] = f1;
               end else begin
                  s.addr = f0;
                  s.data = f1;
                  store_q.push_back(s);
               end
            end
            "R": begin
               n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
               assert (n == 5) else plain_failure("a retire line is malformed");
               r.pc    = f0;
               r.rf_we = f1[0];
               r.wsel  = f2[2:0];
               r.wdata = f3;
               r.gap   = f4[7:0];
               retire_q.push_back(r);
            end
            default: ;
         endcase
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   task automatic compare_retire();
      exp_retire_t want;
      if (retire_q.size() == 0) begin
         plain_failure("an instruction retired after the last expected record");
      end else begin
         want = retire_q.pop_front();
         assert (o_retire.pc == want.pc)
            else value_mismatch("o_retire.pc", o_retire.pc, want.pc);
         // the retired word is the program word at that address
         assert (o_retire.insn == imem[want.pc])
            else value_mismatch("o_retire.insn", o_retire.insn, imem[want.pc]);
         assert (o_retire.rf_we == want.rf_we)
            else value_mismatch("o_retire.rf_we", o_retire.rf_we, want.rf_we);
         // wsel and wdata only carry meaning for a register write
         if (want.rf_we) begin
            assert (o_retire.wsel == want.wsel)
               else value_mismatch("o_retire.wsel", o_retire.wsel, want.wsel);
            assert (o_retire.wdata == want.wdata)
               else value_mismatch("o_retire.wdata", o_retire.wdata, want.wdata);
         end
         // stalls and flushes show up as idle slots
         assert (idle_cycles == want.gap)
            else value_mismatch("o_retire.valid idle gap", idle_cycles, want.gap);
      end
   endtask

   task automatic verify_store();
      exp_store_t want;
      if (store_q.size() == 0) begin
         plain_failure("a store happened after the last expected store");
      end else begin
         want = store_q.pop_front();
         assert (o_dmem_addr == want.addr)
            else value_mismatch("o_dmem_addr", o_dmem_addr, want.addr);
         assert (o_dmem_wdata == want.data)
            else value_mismatch("o_dmem_wdata", o_dmem_wdata, want.data);
      end
   endtask

   // memories answer the current addresses shortly after each edge
   always @(posedge gwe) begin
      #1;
      i_imem_data = imem[o_imem_addr];
      i_dmem_data = dmem[o_dmem_addr];
   end

   // outputs are stable at the falling edge
   always @(negedge gwe) begin
      if (!i_reset && loaded) begin
         if (o_dmem_we) begin
            verify_store();
            dmem[o_dmem_addr] = o_dmem_wdata;
         end
         if (o_retire.valid) begin
            compare_retire();
            idle_cycles = 0;
         end else begin
            idle_cycles++;
         end
      end
   end

   // reset cycles plus three per expected retire and some slack
   initial begin
      wait (loaded);
      repeat (8 + retire_total * 3 + 40) @(posedge gwe);
      plain_failure("timeout while waiting for the expected retires and stores");
   end

   initial begin
      i_reset     = 1'b1;
      i_imem_data = '0;
      i_dmem_data = '0;
      loaded      = 1'b0;
      idle_cycles = 0;
      for (int a = 0; a < 65536; a++) begin
         // opcode 1111 is outside the kept set so unloaded fetches never retire
         imem[a] = {4'hF, a[15:4] ^ a[11:0]};
         dmem[a] = {a[7:0], a[15:8]} ^ 16'h5a3c;
      end
      load_vectors();
      retire_total = retire_q.size();
      loaded = 1'b1;
      repeat (8) @(posedge gwe);
      #1;
      i_reset = 1'b0;
      // first cycle out of reset
      @(negedge gwe);
      assert (o_imem_addr == FIRST_PC)
         else value_mismatch("o_imem_addr", o_imem_addr, FIRST_PC);
      assert (o_retire.valid == 1'b0)
         else value_mismatch("o_retire.valid", o_retire.valid, 16'h0);
      assert (o_dmem_we == 1'b0)
         else value_mismatch("o_dmem_we", o_dmem_we, 16'h0);
      while (retire_q.size() != 0) begin
         @(posedge gwe);
      end
      // room for a stray retire or store to show up
      repeat (8) @(posedge gwe);
      // every store writes memory one cycle before it retires
      if (store_q.size() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         plain_failure("expected stores were left unmatched");
      end
   end

endmodule

//--- lc4_pipeline.f
hw/lc4_isa_pkg.sv
hw/lc4_pipe_pkg.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_fetch.sv
hw/lc4_decode_stage.sv
hw/lc4_execute.sv
hw/lc4_memory_stage.sv
hw/lc4_pipeline.sv
verif/lc4_pipeline_tb.sv

//--- verif/lc4_program_vectors.txt
# I addr insn | D addr data | R pc rf_we wsel wdata idle_before | S addr data
# all fields hex, wsel and wdata are ignored when rf_we is 0
D 0041 1234
D 0042 beef
D 0043 7777
# straight-line ALU with MX and WX bypass
I 8200 9240
I 8201 9405
I 8202 97fd
I 8203 1883
I 8204 1b39
I 8205 5d43
I 8206 5fae
# load-use stall, then load feeding a store and a load after the store
I 8207 6441
I 8208 1687
I 8209 6842
I 820a 7843
I 820b 6a43
# BRz not taken on a negative load, then BRz taken on zero
I 820c 0402
I 820d 1d61
I 820e 9000
I 820f 0402
I 8210 1021
I 8211 1022
I 8212 1225
I 8213 7250
# BRp taken, 8216 and 8217 are flushed
I 8214 547f
I 8215 0202
I 8216 9655
I 8217 9866
I 8218 1682
I 8219 767f
R 8200 1 1 0040 04
R 8201 1 2 0005 00
R 8202 1 3 fffd 00
R 8203 1 4 0002 00
R 8204 1 5 fffb 00
R 8205 1 6 fff9 00
R 8206 1 7 0008 00
R 8207 1 2 1234 00
R 8208 1 3 123c 01
R 8209 1 4 beef 00
R 820a 0 0 0000 00
R 820b 1 5 beef 00
R 820c 0 0 0000 00
R 820d 1 6 bef0 00
R 820e 1 0 0000 00
R 820f 0 0 0000 00
R 8212 1 1 0005 02
R 8213 0 0 0000 00
R 8214 1 2 0005 00
R 8215 0 0 0000 00
R 8218 1 3 000a 02
R 8219 0 0 0000 00
S 0043 beef
S 0015 0005
S 0004 000a
